// File: logic/cache_directory.sv
// Set-associative cache directory
module cache_directory #(
    parameter int WAYS = l1_cache_pkg::D_WAYS
) (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                cmd_valid_i,
    input  l1_cache_pkg::cmd_e  cmd_i,
    input  l1_cache_pkg::addr_t addr_i,
    input  logic                shared_i,
    output logic                resp_valid_o,
    output logic                resp_hit_o,
    output l1_cache_pkg::way_t  resp_way_o,
    output l1_cache_pkg::mesi_e resp_mesi_o,
    output logic                resp_writeback_o,
    output l1_cache_pkg::tag_t  resp_wb_tag_o
);
    import l1_cache_pkg::*;

    // Address split
    tag_t   lookup_tag;
    index_t lookup_index;

    // Current and rewritten set
    tag_t  rd_tag  [WAYS];
    mesi_e rd_mesi [WAYS];
    age_t  rd_age  [WAYS];
    tag_t  wr_tag  [WAYS];
    mesi_e wr_mesi [WAYS];
    age_t  age_next [WAYS];

    // Per-way flags
    logic [WAYS-1:0] hit_vec;
    logic [WAYS-1:0] chosen;

    // Selected way
    logic  sel_hit;
    way_t  sel_way;
    mesi_e sel_mesi;
    age_t  sel_age;
    tag_t  sel_tag;

    // MESI result
    mesi_e new_mesi;
    logic  writeback;
    logic  touch;
    logic  fill;

    // Command qualifiers
    logic cmd_req;
    logic clear;
    logic wr_en;

    assign lookup_tag   = addr_i[ADDR_W-1 -: TAG_W];
    assign lookup_index = addr_i[OFFSET_W +: INDEX_W];

    // Clear never answers, everything else does
    assign clear   = cmd_valid_i && (cmd_i == CMD_CLEAR);
    assign cmd_req = cmd_valid_i && (cmd_i != CMD_CLEAR);

    // Snoop misses leave the set untouched
    assign wr_en = cmd_req && (touch || sel_hit);

    tag_array #(
        .WAYS (WAYS)
    ) u_tag_array (
        .clk        (clk),
        .rst_i      (rst_i),
        .clear_i    (clear),
        .rd_index_i (lookup_index),
        .wr_en_i    (wr_en),
        .wr_index_i (lookup_index),
        .wr_tag_i   (wr_tag),
        .wr_mesi_i  (wr_mesi),
        .wr_age_i   (age_next),
        .rd_tag_o   (rd_tag),
        .rd_mesi_o  (rd_mesi),
        .rd_age_o   (rd_age)
    );

    for (genvar g = 0; g < WAYS; g++) begin : g_way
        assign chosen[g] = (sel_way == way_t'(g));

        way_slice u_way_slice (
            .tag_i        (rd_tag[g]),
            .mesi_i       (rd_mesi[g]),
            .age_i        (rd_age[g]),
            .lookup_tag_i (lookup_tag),
            .touch_i      (touch),
            .chosen_i     (chosen[g]),
            .chosen_age_i (sel_age),
            .hit_o        (hit_vec[g]),
            .age_next_o   (age_next[g])
        );

        // Chosen way takes the new state, and the new tag on a fill
        assign wr_tag[g]  = (chosen[g] && fill) ? lookup_tag : rd_tag[g];
        assign wr_mesi[g] = chosen[g] ? new_mesi : rd_mesi[g];
    end

    replace_select #(
        .WAYS (WAYS)
    ) u_replace_select (
        .hit_i      (hit_vec),
        .mesi_i     (rd_mesi),
        .age_i      (rd_age),
        .tag_i      (rd_tag),
        .hit_o      (sel_hit),
        .way_o      (sel_way),
        .sel_mesi_o (sel_mesi),
        .sel_age_o  (sel_age),
        .sel_tag_o  (sel_tag)
    );

    mesi_next u_mesi_next (
        .cmd_i       (cmd_i),
        .hit_i       (sel_hit),
        .mesi_i      (sel_mesi),
        .shared_i    (shared_i),
        .mesi_o      (new_mesi),
        .writeback_o (writeback),
        .touch_o     (touch),
        .fill_o      (fill)
    );

    // One-cycle response pulses
    always_ff @(posedge clk) begin
        if (rst_i) begin
            resp_valid_o     <= 1'b0;
            resp_writeback_o <= 1'b0;
        end else begin
            resp_valid_o     <= cmd_req;
            resp_writeback_o <= cmd_req && writeback;
        end
    end

    // Response payload, held between commands
    always_ff @(posedge clk) begin
        if (cmd_req) begin
            resp_hit_o    <= sel_hit;
            resp_way_o    <= sel_way;
            resp_mesi_o   <= new_mesi;
            // Displaced or snooped tag, zero when nothing goes out
            resp_wb_tag_o <= writeback ? sel_tag : '0;
        end
    end

endmodule

// File: logic/l1_cache_pkg.sv
// L1 directory definitions
package l1_cache_pkg;

    // Address geometry
    // Tag in the upper bits, set index in the middle, line offset below
    localparam int ADDR_W   = 32;
    localparam int OFFSET_W = 6;
    localparam int INDEX_W  = 6;
    localparam int SETS     = 64;
    localparam int TAG_W    = 20;

    // Associativity of the two directories
    localparam int D_WAYS   = 8;
    localparam int I_WAYS   = 4;

    // Widest directory sets the width of way and age fields
    localparam int MAX_WAYS = 8;

    // Trace opcodes
    // Codes 5 to 7 are unused, 9 (print) is not handled
    typedef enum logic [3:0] {
        CMD_READ        = 4'd0,
        CMD_WRITE       = 4'd1,
        CMD_FETCH       = 4'd2,
        CMD_SNOOP_INVAL = 4'd3,
        CMD_SNOOP_READ  = 4'd4,
        CMD_CLEAR       = 4'd8
    } cmd_e;

    // Line state
    // Invalid is the all-zero code so a cleared set reads as empty
    typedef enum logic [1:0] {
        MESI_I = 2'd0,
        MESI_S = 2'd1,
        MESI_E = 2'd2,
        MESI_M = 2'd3
    } mesi_e;

    // Full command address
    typedef logic [ADDR_W-1:0] addr_t;

    // Address fields
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [INDEX_W-1:0] index_t;

    // LRU age per way
    // Zero is most recent, higher is older
    typedef logic [$clog2(MAX_WAYS)-1:0] age_t;

    // Way number inside a set
    typedef logic [$clog2(MAX_WAYS)-1:0] way_t;

endpackage

// File: logic/l1_split_directory.sv
// Split L1 directory top
module l1_split_directory (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                cmd_valid_i,
    input  l1_cache_pkg::cmd_e  cmd_i,
    input  l1_cache_pkg::addr_t addr_i,
    input  logic                shared_i,
    output logic                d_resp_valid_o,
    output logic                d_resp_hit_o,
    output l1_cache_pkg::way_t  d_resp_way_o,
    output l1_cache_pkg::mesi_e d_resp_mesi_o,
    output logic                d_resp_writeback_o,
    output l1_cache_pkg::tag_t  d_resp_wb_tag_o,
    output logic                i_resp_valid_o,
    output logic                i_resp_hit_o,
    output l1_cache_pkg::way_t  i_resp_way_o,
    output l1_cache_pkg::mesi_e i_resp_mesi_o,
    output logic                i_resp_writeback_o,
    output l1_cache_pkg::tag_t  i_resp_wb_tag_o
);
    import l1_cache_pkg::*;

    // Per-directory strobes
    logic d_cmd_valid;
    logic i_cmd_valid;

    // Fetch is instruction side only, clear reaches both
    assign d_cmd_valid = cmd_valid_i && (cmd_i != CMD_FETCH);
    assign i_cmd_valid = cmd_valid_i && ((cmd_i == CMD_FETCH) || (cmd_i == CMD_CLEAR));

    // Data directory, 8 ways
    cache_directory #(
        .WAYS (D_WAYS)
    ) u_dcache_dir (
        .clk              (clk),
        .rst_i            (rst_i),
        .cmd_valid_i      (d_cmd_valid),
        .cmd_i            (cmd_i),
        .addr_i           (addr_i),
        .shared_i         (shared_i),
        .resp_valid_o     (d_resp_valid_o),
        .resp_hit_o       (d_resp_hit_o),
        .resp_way_o       (d_resp_way_o),
        .resp_mesi_o      (d_resp_mesi_o),
        .resp_writeback_o (d_resp_writeback_o),
        .resp_wb_tag_o    (d_resp_wb_tag_o)
    );

    // Instruction directory, 4 ways
    cache_directory #(
        .WAYS (I_WAYS)
    ) u_icache_dir (
        .clk              (clk),
        .rst_i            (rst_i),
        .cmd_valid_i      (i_cmd_valid),
        .cmd_i            (cmd_i),
        .addr_i           (addr_i),
        .shared_i         (shared_i),
        .resp_valid_o     (i_resp_valid_o),
        .resp_hit_o       (i_resp_hit_o),
        .resp_way_o       (i_resp_way_o),
        .resp_mesi_o      (i_resp_mesi_o),
        .resp_writeback_o (i_resp_writeback_o),
        .resp_wb_tag_o    (i_resp_wb_tag_o)
    );

endmodule

// File: logic/mesi_next.sv
// MESI transition logic
module mesi_next (
    input  l1_cache_pkg::cmd_e  cmd_i,
    input  logic                hit_i,
    input  l1_cache_pkg::mesi_e mesi_i,
    input  logic                shared_i,
    output l1_cache_pkg::mesi_e mesi_o,
    output logic                writeback_o,
    output logic                touch_o,
    output logic                fill_o
);
    import l1_cache_pkg::*;

    always_comb begin
        // Default keeps the line as it is
        mesi_o      = mesi_i;
        writeback_o = 1'b0;
        touch_o     = 1'b0;
        fill_o      = 1'b0;
        case (cmd_i)
            CMD_READ, CMD_FETCH: begin
                touch_o = 1'b1;
                if (!hit_i) begin
                    // Fill from L2, exclusive unless another cache holds it
                    fill_o      = 1'b1;
                    mesi_o      = shared_i ? MESI_S : MESI_E;
                    writeback_o = (mesi_i == MESI_M);
                end
            end
            CMD_WRITE: begin
                // Write allocate, line always ends up modified
                touch_o = 1'b1;
                mesi_o  = MESI_M;
                if (!hit_i) begin
                    fill_o      = 1'b1;
                    writeback_o = (mesi_i == MESI_M);
                end
            end
            CMD_SNOOP_INVAL: begin
                // Miss reports invalid and leaves the set alone
                mesi_o = MESI_I;
                if (hit_i) begin
                    writeback_o = (mesi_i == MESI_M);
                end
            end
            CMD_SNOOP_READ: begin
                if (hit_i) begin
                    // M and E drop to shared, S stays
                    mesi_o      = MESI_S;
                    writeback_o = (mesi_i == MESI_M);
                end else begin
                    mesi_o = MESI_I;
                end
            end
            default: begin
                // Clear and unused codes change nothing here
            end
        endcase
    end

endmodule

// File: logic/replace_select.sv
// Hit encoder and victim selection
module replace_select #(
    parameter int WAYS = l1_cache_pkg::D_WAYS
) (
    input  logic [WAYS-1:0]     hit_i,
    input  l1_cache_pkg::mesi_e mesi_i [WAYS],
    input  l1_cache_pkg::age_t  age_i  [WAYS],
    input  l1_cache_pkg::tag_t  tag_i  [WAYS],
    output logic                hit_o,
    output l1_cache_pkg::way_t  way_o,
    output l1_cache_pkg::mesi_e sel_mesi_o,
    output l1_cache_pkg::age_t  sel_age_o,
    output l1_cache_pkg::tag_t  sel_tag_o
);
    import l1_cache_pkg::*;

    // Encoded hit way
    way_t hit_way;

    // Oldest invalid way, if any
    logic inv_found;
    way_t inv_way;
    age_t inv_age;

    // Way holding the top age
    way_t old_way;

    // Any valid tag match
    assign hit_o = |hit_i;

    // Hit vector is one-hot when any bit is set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (hit_i[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    // Victim search over the whole set
    // Ages form a permutation so the top age is always present
    always_comb begin
        inv_found = 1'b0;
        inv_way   = '0;
        inv_age   = '0;
        old_way   = '0;
        for (int w = 0; w < WAYS; w++) begin
            if ((mesi_i[w] == MESI_I) && (!inv_found || (age_i[w] > inv_age))) begin
                inv_found = 1'b1;
                inv_way   = way_t'(w);
                inv_age   = age_i[w];
            end
            if (age_i[w] == age_t'(WAYS - 1)) begin
                old_way = way_t'(w);
            end
        end
    end

    // Hit wins, then an empty way, then the oldest line
    assign way_o = hit_o ? hit_way : (inv_found ? inv_way : old_way);

    // Present the chosen way's fields
    always_comb begin
        sel_mesi_o = MESI_I;
        sel_age_o  = '0;
        sel_tag_o  = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (way_o == way_t'(w)) begin
                sel_mesi_o = mesi_i[w];
                sel_age_o  = age_i[w];
                sel_tag_o  = tag_i[w];
            end
        end
    end

endmodule

// File: logic/tag_array.sv
// Directory tag array
module tag_array #(
    parameter int WAYS = l1_cache_pkg::D_WAYS
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 clear_i,
    input  l1_cache_pkg::index_t rd_index_i,
    input  logic                 wr_en_i,
    input  l1_cache_pkg::index_t wr_index_i,
    input  l1_cache_pkg::tag_t   wr_tag_i  [WAYS],
    input  l1_cache_pkg::mesi_e  wr_mesi_i [WAYS],
    input  l1_cache_pkg::age_t   wr_age_i  [WAYS],
    output l1_cache_pkg::tag_t   rd_tag_o  [WAYS],
    output l1_cache_pkg::mesi_e  rd_mesi_o [WAYS],
    output l1_cache_pkg::age_t   rd_age_o  [WAYS]
);
    import l1_cache_pkg::*;

    // Per-set storage, one entry per way
    tag_t  tag_mem  [SETS][WAYS];
    mesi_e mesi_mem [SETS][WAYS];
    age_t  age_mem  [SETS][WAYS];

    // State and age words
    // Reset and clear empty every set and restore the age ladder
    always_ff @(posedge clk) begin
        if (rst_i || clear_i) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    mesi_mem[s][w] <= MESI_I;
                    // Way w starts at age w
                    age_mem[s][w]  <= age_t'(w);
                end
            end
        end else if (wr_en_i) begin
            // Whole set is replaced in one write
            for (int w = 0; w < WAYS; w++) begin
                mesi_mem[wr_index_i][w] <= wr_mesi_i[w];
                age_mem[wr_index_i][w]  <= wr_age_i[w];
            end
        end
    end

    // Tag words
    // Only meaningful while the matching state is valid
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            for (int w = 0; w < WAYS; w++) begin
                tag_mem[wr_index_i][w] <= wr_tag_i[w];
            end
        end
    end

    // Combinational read of the addressed set
    // A write at the edge is visible to the next lookup
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            rd_tag_o[w]  = tag_mem[rd_index_i][w];
            rd_mesi_o[w] = mesi_mem[rd_index_i][w];
            rd_age_o[w]  = age_mem[rd_index_i][w];
        end
    end

endmodule

// File: logic/way_slice.sv
// Single way compare and age update
module way_slice (
    input  l1_cache_pkg::tag_t  tag_i,
    input  l1_cache_pkg::mesi_e mesi_i,
    input  l1_cache_pkg::age_t  age_i,
    input  l1_cache_pkg::tag_t  lookup_tag_i,
    input  logic                touch_i,
    input  logic                chosen_i,
    input  l1_cache_pkg::age_t  chosen_age_i,
    output logic                hit_o,
    output l1_cache_pkg::age_t  age_next_o
);
    import l1_cache_pkg::*;

    // Valid line with a matching tag
    assign hit_o = (mesi_i != MESI_I) && (tag_i == lookup_tag_i);

    // LRU ageing
    // Chosen way becomes newest, ways younger than it move up by one
    always_comb begin
        age_next_o = age_i;
        if (touch_i) begin
            if (chosen_i) begin
                age_next_o = '0;
            end else if (age_i < chosen_age_i) begin
                age_next_o = age_i + 1'b1;
            end
        end
    end

endmodule

// File: sources.f
+incdir+testbench
logic/l1_cache_pkg.sv
logic/tag_array.sv
logic/way_slice.sv
logic/replace_select.sv
logic/mesi_next.sv
logic/cache_directory.sv
logic/l1_split_directory.sv
testbench/l1_directory_props.sv
testbench/tb_l1_split_directory.sv

// File: testbench/l1_directory_props.sv
// Directory response properties
module l1_directory_props (
    input logic               clk,
    input logic               rst_i,
    input logic               cmd_valid_i,
    input l1_cache_pkg::cmd_e cmd_i,
    input logic               resp_valid_i,
    input logic               resp_writeback_i,
    input l1_cache_pkg::mesi_e resp_mesi_i
);
    import l1_cache_pkg::*;

    // Commands that answer, and writes among them
    logic req;
    logic write_req;

    // Number of property failures in this directory
    int fail_count = 0;

    assign req       = cmd_valid_i && (cmd_i != CMD_CLEAR);
    assign write_req = cmd_valid_i && (cmd_i == CMD_WRITE);

    // Response one cycle after every answering command
    a_resp_follows: assert property (@(posedge clk) disable iff (rst_i) req |=> resp_valid_i)
        else begin
            fail_count++;
            $error("no response one cycle after a command");
        end

    // And never without one
    a_resp_only: assert property (@(posedge clk) disable iff (rst_i) !req |=> !resp_valid_i)
        else begin
            fail_count++;
            $error("response without a command");
        end

    a_wb_in_resp: assert property (@(posedge clk) disable iff (rst_i)
        resp_writeback_i |-> resp_valid_i)
        else begin
            fail_count++;
            $error("writeback flag outside a response");
        end

    // Writes always leave the line modified
    a_write_mod: assert property (@(posedge clk) disable iff (rst_i)
        write_req |=> (resp_mesi_i == MESI_M))
        else begin
            fail_count++;
            $error("write response not in modified state");
        end

endmodule

bind cache_directory l1_directory_props u_directory_props (
    .clk              (clk),
    .rst_i            (rst_i),
    .cmd_valid_i      (cmd_valid_i),
    .cmd_i            (cmd_i),
    .resp_valid_i     (resp_valid_o),
    .resp_writeback_i (resp_writeback_o),
    .resp_mesi_i      (resp_mesi_o)
);

// File: testbench/tb_l1_model.svh
// Split directory reference model
`ifndef TB_L1_MODEL_SVH
`define TB_L1_MODEL_SVH

// Expected response of one directory in one cycle
typedef struct packed {
    logic  valid;
    logic  hit;
    way_t  way;
    mesi_e mesi;
    logic  wb;
    tag_t  wb_tag;
} resp_s;

// Model arrays
// Entry 0 is the data side and entry 1 the instruction side
tag_t  m_tag  [2][SETS][MAX_WAYS];
mesi_e m_mesi [2][SETS][MAX_WAYS];
age_t  m_age  [2][SETS][MAX_WAYS];

// Mismatch counters by result kind
int valid_errors = 0;
int hit_errors   = 0;
int way_errors   = 0;
int mesi_errors  = 0;
int wb_errors    = 0;
int tag_errors   = 0;

// Empty every set, way w at age w
task automatic model_reset(input int side);
    for (int s = 0; s < SETS; s++) begin
        for (int w = 0; w < MAX_WAYS; w++) begin
            m_tag[side][s][w]  = '0;
            m_mesi[side][s][w] = MESI_I;
            m_age[side][s][w]  = age_t'(w);
        end
    end
endtask

// One non-clear command against one directory
task automatic model_access(input int side, input int ways, input cmd_e cmd,
                            input tag_t tag, input index_t idx, input logic shared,
                            output resp_s r);
    int    pick;
    logic  found_inv;
    age_t  best_age;
    logic  touch;
    logic  fill;
    mesi_e old;
    age_t  pick_age;
    r         = '0;
    r.valid   = 1'b1;
    pick      = 0;
    found_inv = 1'b0;
    best_age  = '0;
    touch     = 1'b0;
    fill      = 1'b0;
    // A valid line with a matching tag
    for (int w = 0; w < ways; w++) begin
        if ((m_mesi[side][idx][w] != MESI_I) && (m_tag[side][idx][w] == tag)) begin
            r.hit = 1'b1;
            pick  = w;
        end
    end
    if (!r.hit) begin
        // Oldest invalid way first
        for (int w = 0; w < ways; w++) begin
            if ((m_mesi[side][idx][w] == MESI_I) &&
                (!found_inv || (m_age[side][idx][w] > best_age))) begin
                found_inv = 1'b1;
                best_age  = m_age[side][idx][w];
                pick      = w;
            end
        end
        // Otherwise the way at the top age
        if (!found_inv) begin
            for (int w = 0; w < ways; w++) begin
                if (m_age[side][idx][w] == age_t'(ways - 1)) begin
                    pick = w;
                end
            end
        end
    end
    old      = m_mesi[side][idx][pick];
    pick_age = m_age[side][idx][pick];
    r.way    = way_t'(pick);
    r.mesi   = old;
    case (cmd)
        CMD_READ, CMD_FETCH: begin
            touch = 1'b1;
            if (!r.hit) begin
                fill   = 1'b1;
                r.mesi = shared ? MESI_S : MESI_E;
                r.wb   = (old == MESI_M);
            end
        end
        CMD_WRITE: begin
            touch  = 1'b1;
            r.mesi = MESI_M;
            if (!r.hit) begin
                fill = 1'b1;
                r.wb = (old == MESI_M);
            end
        end
        CMD_SNOOP_INVAL: begin
            r.mesi = MESI_I;
            r.wb   = r.hit && (old == MESI_M);
        end
        CMD_SNOOP_READ: begin
            r.mesi = r.hit ? MESI_S : MESI_I;
            r.wb   = r.hit && (old == MESI_M);
        end
        default: begin
        end
    endcase
    if (r.wb) begin
        r.wb_tag = m_tag[side][idx][pick];
    end
    // Younger ways age by one, chosen way becomes newest
    if (touch) begin
        for (int w = 0; w < ways; w++) begin
            if (m_age[side][idx][w] < pick_age) begin
                m_age[side][idx][w] = m_age[side][idx][w] + 1'b1;
            end
        end
        m_age[side][idx][pick] = '0;
    end
    if (fill) begin
        m_tag[side][idx][pick] = tag;
    end
    // Snoop misses leave the set alone
    if (r.hit || touch) begin
        m_mesi[side][idx][pick] = r.mesi;
    end
endtask

task automatic check_hit(input string what, input logic act, input logic exp);
    if (act !== exp) begin
        $display("FAIL %0t: %s hit flag %b, expected %b", $time, what, act, exp);
        hit_errors++;
    end
endtask

task automatic check_writeback(input string what, input logic act, input logic exp);
    if (act !== exp) begin
        $display("FAIL %0t: %s writeback flag %b, expected %b", $time, what, act, exp);
        wb_errors++;
    end
endtask

task automatic check_way(input string what, input way_t act, input way_t exp);
    if (act !== exp) begin
        $display("FAIL %0t: %s way %0d, expected %0d", $time, what, act, exp);
        way_errors++;
    end
endtask

task automatic check_mesi(input string what, input mesi_e act, input mesi_e exp);
    if (act !== exp) begin
        $display("FAIL %0t: %s state %s, expected %s", $time, what, act.name(), exp.name());
        mesi_errors++;
    end
endtask

task automatic check_tag(input string what, input tag_t act, input tag_t exp);
    if (act !== exp) begin
        $display("FAIL %0t: %s writeback tag %h, expected %h", $time, what, act, exp);
        tag_errors++;
    end
endtask

`endif

// File: testbench/tb_l1_split_directory.sv
// Split L1 directory testbench
module tb_l1_split_directory;
    import l1_cache_pkg::*;

    localparam int NUM_CMDS       = 2000;
    localparam int TIMEOUT_CYCLES = NUM_CMDS * 2 + 100;

    logic  clk;
    logic  rst_i;
    logic  cmd_valid_i;
    cmd_e  cmd_i;
    addr_t addr_i;
    logic  shared_i;

    // Data side responses
    logic  d_resp_valid_o;
    logic  d_resp_hit_o;
    way_t  d_resp_way_o;
    mesi_e d_resp_mesi_o;
    logic  d_resp_writeback_o;
    tag_t  d_resp_wb_tag_o;

    // Instruction side responses
    logic  i_resp_valid_o;
    logic  i_resp_hit_o;
    way_t  i_resp_way_o;
    mesi_e i_resp_mesi_o;
    logic  i_resp_writeback_o;
    tag_t  i_resp_wb_tag_o;

    integer seed;
    int     cycle_count = 0;

    `include "tb_l1_model.svh"

    // Expected responses, current cycle and the one after
    resp_s exp_d_now;
    resp_s exp_i_now;
    resp_s exp_d_next;
    resp_s exp_i_next;

    l1_split_directory u_l1_split_directory (
        .clk                (clk),
        .rst_i              (rst_i),
        .cmd_valid_i        (cmd_valid_i),
        .cmd_i              (cmd_i),
        .addr_i             (addr_i),
        .shared_i           (shared_i),
        .d_resp_valid_o     (d_resp_valid_o),
        .d_resp_hit_o       (d_resp_hit_o),
        .d_resp_way_o       (d_resp_way_o),
        .d_resp_mesi_o      (d_resp_mesi_o),
        .d_resp_writeback_o (d_resp_writeback_o),
        .d_resp_wb_tag_o    (d_resp_wb_tag_o),
        .i_resp_valid_o     (i_resp_valid_o),
        .i_resp_hit_o       (i_resp_hit_o),
        .i_resp_way_o       (i_resp_way_o),
        .i_resp_mesi_o      (i_resp_mesi_o),
        .i_resp_writeback_o (i_resp_writeback_o),
        .i_resp_wb_tag_o    (i_resp_wb_tag_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Compare one directory's outputs with the model
    task automatic compare_response(input string side, input logic valid, input logic hit,
                                    input way_t way, input mesi_e mesi, input logic wb,
                                    input tag_t wb_tag, input resp_s exp);
        if (valid !== exp.valid) begin
            $display("%s directory response %s at time %0t", side,
                     exp.valid ? "is missing" : "came without a command", $time);
            valid_errors++;
        end else if (exp.valid) begin
            check_hit(side, hit, exp.hit);
            check_way(side, way, exp.way);
            check_mesi(side, mesi, exp.mesi);
            check_writeback(side, wb, exp.wb);
            // Tag of the line that goes out, zero when none does
            check_tag(side, wb_tag, exp.wb_tag);
        end
    endtask

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!rst_i) begin
            compare_response("data", d_resp_valid_o, d_resp_hit_o, d_resp_way_o,
                             d_resp_mesi_o, d_resp_writeback_o, d_resp_wb_tag_o, exp_d_now);
            compare_response("instruction", i_resp_valid_o, i_resp_hit_o, i_resp_way_o,
                             i_resp_mesi_o, i_resp_writeback_o, i_resp_wb_tag_o, exp_i_now);
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with commands still pending", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    initial begin : stimulus
        int                  issued;
        int                  pick;
        int                  total;
        int                  assert_errors;
        cmd_e                op;
        tag_t                tag;
        index_t              idx;
        logic [OFFSET_W-1:0] off;
        logic                shr;
        seed        = 63;
        issued      = 0;
        rst_i       = 1'b1;
        cmd_valid_i = 1'b0;
        cmd_i       = CMD_READ;
        addr_i      = '0;
        shared_i    = 1'b0;
        exp_d_now   = '0;
        exp_i_now   = '0;
        exp_d_next  = '0;
        exp_i_next  = '0;
        model_reset(0);
        model_reset(1);
        repeat (5) @(posedge clk);
        rst_i <= 1'b0;
        while (issued < NUM_CMDS) begin
            @(posedge clk);
            exp_d_now  = exp_d_next;
            exp_i_now  = exp_i_next;
            exp_d_next = '0;
            exp_i_next = '0;
            if (($unsigned($random(seed)) % 4) != 0) begin
                pick = $unsigned($random(seed)) % 64;
                // First command is a data read, clear is rare
                if (issued == 0)
                    op = CMD_READ;
                else if (pick == 0)
                    op = CMD_CLEAR;
                else if (pick < 14)
                    op = CMD_READ;
                else if (pick < 27)
                    op = CMD_WRITE;
                else if (pick < 40)
                    op = CMD_FETCH;
                else if (pick < 52)
                    op = CMD_SNOOP_INVAL;
                else
                    op = CMD_SNOOP_READ;
                // Twelve tags over two sets
                tag = 20'h0A5C0 + tag_t'(($unsigned($random(seed)) % 12) * 20'h00111);
                idx = ($random(seed) & 1) ? index_t'(37) : index_t'(5);
                off = $random(seed);
                shr = $random(seed) & 1;
                cmd_valid_i <= 1'b1;
                cmd_i       <= op;
                addr_i      <= {tag, idx, off};
                shared_i    <= shr;
                if (op == CMD_CLEAR) begin
                    model_reset(0);
                    model_reset(1);
                end else if (op == CMD_FETCH) begin
                    model_access(1, I_WAYS, op, tag, idx, shr, exp_i_next);
                end else begin
                    model_access(0, D_WAYS, op, tag, idx, shr, exp_d_next);
                end
                issued++;
            end else begin
                cmd_valid_i <= 1'b0;
            end
        end
        // Drain the last response and one quiet cycle
        @(posedge clk);
        exp_d_now   = exp_d_next;
        exp_i_now   = exp_i_next;
        exp_d_next  = '0;
        exp_i_next  = '0;
        cmd_valid_i <= 1'b0;
        @(posedge clk);
        exp_d_now = '0;
        exp_i_now = '0;
        @(posedge clk);
        assert_errors = u_l1_split_directory.u_dcache_dir.u_directory_props.fail_count +
                        u_l1_split_directory.u_icache_dir.u_directory_props.fail_count;
        total = valid_errors + hit_errors + way_errors + mesi_errors + wb_errors + tag_errors +
                assert_errors;
        $display("Errors: valid %0d hit %0d way %0d state %0d writeback %0d tag %0d %s %0d %s %0d",
                 valid_errors, hit_errors, way_errors, mesi_errors, wb_errors, tag_errors,
                 "assertion", assert_errors, "total", total);
        if (total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
